// File: dv/cpu_bus_assertions.sv
// Concurrent checks on the D-port arbiter
// Grant stability under wait states, reset and debug data phase rules

`default_nettype none

`include "cpu_bus_defines.svh"

module cpu_bus_assertions (
	input wire                       clk,
	input wire                       rst_n,
	input wire cpu_bus_pkg::dgrant_e gnt_i,
	input wire [1:0]                 htrans_i,
	input wire                       hready_i,
	input wire                       hresp_i,
	input wire                       sbus_dph_active_i
);

	// Number of failed assertions
	int fail_cnt = 0;

	// Stalled address phase keeps its owner
	assert property (@(posedge clk) disable iff (!rst_n)
		(htrans_i == `CPU_BUS_HTRANS_NSEQ && !hready_i && !hresp_i) |=> (gnt_i == $past(gnt_i)))
		else begin
			$error("grant changed during a stalled address phase");
			fail_cnt++;
		end

	assert property (@(posedge clk) !rst_n |-> (gnt_i == cpu_bus_pkg::DGNT_NONE))
		else begin
			$error("grant given while in reset");
			fail_cnt++;
		end

	// One debug transfer at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		sbus_dph_active_i |-> (gnt_i != cpu_bus_pkg::DGNT_SBUS))
		else begin
			$error("debug grant while a debug data phase is open");
			fail_cnt++;
		end

endmodule

bind dport_arbiter cpu_bus_assertions u_cpu_bus_assertions (
	.clk               (clk),
	.rst_n             (rst_n),
	.gnt_i             (gnt_o),
	.htrans_i          (d_htrans_i),
	.hready_i          (d_hready_i),
	.hresp_i           (d_hresp_i),
	.sbus_dph_active_i (sbus_dph_active_i)
);

`default_nettype wire

// File: dv/tb_cpu_bus_2port.sv
// Testbench for the two-port AHB-Lite bus front end
// AHB slave memory model, core and debugger stimulus, reference model,
// response checker and cycle-count timeout

`default_nettype none

`include "cpu_bus_defines.svh"

// AHB-Lite slave with wait states, two-cycle error response and word storage
module ahb_slave_model (
	input  wire         clk,
	input  wire         rst_n,
	input  wire [1:0]   htrans_i,
	input  wire [31:0]  haddr_i,
	input  wire         hwrite_i,
	input  wire [31:0]  hwdata_i,
	input  wire [1:0]   wait_i,
	output logic        hready_o,
	output logic        hresp_o,
	output logic [31:0] hrdata_o
);

	logic [31:0] mem [logic [31:0]];
	logic        dph_vld;
	logic [31:0] dph_addr;
	logic        dph_write;
	logic        dph_err;
	logic [1:0]  wait_cnt;

	// Address and data phase tracking
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_vld   <= 1'b0;
			dph_addr  <= 32'h0;
			dph_write <= 1'b0;
			dph_err   <= 1'b0;
			wait_cnt  <= 2'd0;
		end else begin
			if (dph_vld && hready_o) begin
				if (dph_write && !dph_err) begin
					mem[dph_addr] = hwdata_i;
				end
				dph_vld <= 1'b0;
			end else if (dph_vld) begin
				wait_cnt <= wait_cnt - 2'd1;
			end
			if (htrans_i == `CPU_BUS_HTRANS_NSEQ && hready_o) begin
				dph_vld   <= 1'b1;
				dph_addr  <= haddr_i;
				dph_write <= hwrite_i;
				dph_err   <= haddr_i[31];
				// Error takes exactly two cycles
				wait_cnt  <= haddr_i[31] ? 2'd1 : wait_i;
			end
		end
	end

	// Responses change on the falling edge
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hready_o <= 1'b1;
			hresp_o  <= 1'b0;
			hrdata_o <= 32'h0;
		end else if (!dph_vld) begin
			hready_o <= 1'b1;
			hresp_o  <= 1'b0;
		end else begin
			hready_o <= (wait_cnt == 2'd0);
			hresp_o  <= dph_err;
			hrdata_o <= mem.exists(dph_addr) ? mem[dph_addr] : (dph_addr ^ 32'h5a5a5a5a);
		end
	end

endmodule

module tb_cpu_bus_2port;

	localparam int N_XFER    = 43;
	localparam int CYC_LIMIT = N_XFER * 10 + 200;

	logic        clk;
	logic        rst_n;

	logic        core_i_req_i, core_i_priv_i;
	logic [31:0] core_i_addr_i;
	logic [2:0]  core_i_size_i;
	logic        core_i_aph_ready_o, core_i_dph_ready_o, core_i_dph_err_o;
	logic [31:0] core_i_rdata_o;

	logic        core_d_req_i, core_d_priv_i, core_d_write_i;
	logic [31:0] core_d_addr_i, core_d_wdata_i;
	logic [2:0]  core_d_size_i;
	logic        core_d_aph_ready_o, core_d_dph_ready_o, core_d_dph_err_o;
	logic [31:0] core_d_rdata_o;

	logic        sbus_vld_i, sbus_write_i;
	logic [31:0] sbus_addr_i, sbus_wdata_i;
	logic [1:0]  sbus_size_i;
	logic        sbus_rdy_o, sbus_err_o;
	logic [31:0] sbus_rdata_o;

	logic [31:0] i_haddr, i_hrdata, d_haddr, d_hwdata, d_hrdata;
	logic [1:0]  i_htrans, d_htrans;
	logic [2:0]  i_hsize, d_hsize;
	logic [3:0]  i_hprot, d_hprot;
	logic        i_hwrite, i_hready, i_hresp;
	logic        d_hwrite, d_hready, d_hresp;
	logic [7:0]  d_hmaster;

	logic [31:0] lfsr;
	logic [1:0]  i_wait_tab [64];
	logic [1:0]  d_wait_tab [64];
	logic [5:0]  i_wait_idx, d_wait_idx;
	logic [31:0] shadow [logic [31:0]];

	int          errors, n_checks, cyc, core_aph_cyc, sbus_aph_cyc;

	// Expected transfers, set before each request is driven
	logic [31:0] i_exp_addr, core_exp_addr, core_exp_wdata, sbus_exp_addr, sbus_exp_wdata;
	logic        i_exp_priv, i_exp_err, core_exp_priv, core_exp_write, core_exp_err;
	logic        sbus_exp_write, sbus_exp_err;

	// Stall tracking on the D port
	logic        prev_stall;
	logic [31:0] prev_haddr;
	logic [7:0]  prev_hmaster;

	always #5 clk = ~clk;

	cpu_bus_2port uut (
		.clk(clk), .rst_n(rst_n),
		.core_i_req_i(core_i_req_i), .core_i_addr_i(core_i_addr_i),
		.core_i_size_i(core_i_size_i), .core_i_priv_i(core_i_priv_i),
		.core_i_aph_ready_o(core_i_aph_ready_o), .core_i_dph_ready_o(core_i_dph_ready_o),
		.core_i_dph_err_o(core_i_dph_err_o), .core_i_rdata_o(core_i_rdata_o),
		.core_d_req_i(core_d_req_i), .core_d_addr_i(core_d_addr_i),
		.core_d_size_i(core_d_size_i), .core_d_priv_i(core_d_priv_i),
		.core_d_write_i(core_d_write_i), .core_d_wdata_i(core_d_wdata_i),
		.core_d_aph_ready_o(core_d_aph_ready_o), .core_d_dph_ready_o(core_d_dph_ready_o),
		.core_d_dph_err_o(core_d_dph_err_o), .core_d_rdata_o(core_d_rdata_o),
		.sbus_vld_i(sbus_vld_i), .sbus_addr_i(sbus_addr_i), .sbus_write_i(sbus_write_i),
		.sbus_size_i(sbus_size_i), .sbus_wdata_i(sbus_wdata_i),
		.sbus_rdy_o(sbus_rdy_o), .sbus_err_o(sbus_err_o), .sbus_rdata_o(sbus_rdata_o),
		.i_haddr_o(i_haddr), .i_htrans_o(i_htrans), .i_hsize_o(i_hsize),
		.i_hprot_o(i_hprot), .i_hwrite_o(i_hwrite), .i_hready_i(i_hready),
		.i_hresp_i(i_hresp), .i_hrdata_i(i_hrdata),
		.d_haddr_o(d_haddr), .d_htrans_o(d_htrans), .d_hsize_o(d_hsize),
		.d_hprot_o(d_hprot), .d_hwrite_o(d_hwrite), .d_hmaster_o(d_hmaster),
		.d_hwdata_o(d_hwdata), .d_hready_i(d_hready), .d_hresp_i(d_hresp),
		.d_hrdata_i(d_hrdata)
	);

	ahb_slave_model u_i_slave (
		.clk(clk), .rst_n(rst_n), .htrans_i(i_htrans), .haddr_i(i_haddr),
		.hwrite_i(i_hwrite), .hwdata_i(32'h0), .wait_i(i_wait_tab[i_wait_idx]),
		.hready_o(i_hready), .hresp_o(i_hresp), .hrdata_o(i_hrdata)
	);

	ahb_slave_model u_d_slave (
		.clk(clk), .rst_n(rst_n), .htrans_i(d_htrans), .haddr_i(d_haddr),
		.hwrite_i(d_hwrite), .hwdata_i(d_hwdata), .wait_i(d_wait_tab[d_wait_idx]),
		.hready_o(d_hready), .hresp_o(d_hresp), .hrdata_o(d_hrdata)
	);

	// --------------------------------------------------
	// Random source and reference model

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = 32'h0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Last written word, else the address pattern
	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		return shadow.exists(addr) ? shadow[addr] : (addr ^ 32'h5a5a5a5a);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		@(negedge clk);
		$display("test %s done with %0d errors", name, errors - err_start);
	endtask

	// --------------------------------------------------
	// Requester drivers

	task automatic fetch(input logic [31:0] addr, input logic priv);
		@(negedge clk);
		i_exp_addr    = addr;
		i_exp_priv    = priv;
		i_exp_err     = addr[31];
		core_i_req_i  = 1'b1;
		core_i_addr_i = addr;
		core_i_priv_i = priv;
		do @(posedge clk); while (!core_i_aph_ready_o);
		@(negedge clk);
		core_i_req_i = 1'b0;
		do @(posedge clk); while (!core_i_dph_ready_o);
	endtask

	task automatic core_xfer(input logic [31:0] addr, input logic write,
		input logic [31:0] wdata, input logic priv);
		@(negedge clk);
		core_exp_addr  = addr;
		core_exp_write = write;
		core_exp_wdata = wdata;
		core_exp_priv  = priv;
		core_exp_err   = addr[31];
		core_d_req_i   = 1'b1;
		core_d_addr_i  = addr;
		core_d_write_i = write;
		core_d_wdata_i = wdata;
		core_d_priv_i  = priv;
		do @(posedge clk); while (!core_d_aph_ready_o);
		@(negedge clk);
		core_d_req_i = 1'b0;
		// Write data stays up for the whole data phase
		do @(posedge clk); while (!core_d_dph_ready_o);
	endtask

	task automatic sbus_xfer(input logic [31:0] addr, input logic write, input logic [31:0] wdata);
		@(negedge clk);
		sbus_exp_addr  = addr;
		sbus_exp_write = write;
		sbus_exp_wdata = wdata;
		sbus_exp_err   = addr[31];
		sbus_vld_i     = 1'b1;
		sbus_addr_i    = addr;
		sbus_write_i   = write;
		sbus_wdata_i   = wdata;
		do @(posedge clk); while (!sbus_rdy_o);
		@(negedge clk);
		sbus_vld_i = 1'b0;
	endtask

	// --------------------------------------------------
	// Compare process

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			i_wait_idx <= 6'd0;
			d_wait_idx <= 6'd0;
			prev_stall <= 1'b0;
		end else begin
			if (i_htrans == `CPU_BUS_HTRANS_NSEQ && i_hready) begin
				i_wait_idx <= i_wait_idx + 6'd1;
				check("i_haddr", i_haddr, i_exp_addr);
				check("i_hsize", {29'h0, i_hsize}, {29'h0, core_i_size_i});
				check("i_hwrite", {31'h0, i_hwrite}, 32'h0);
				check("i_hprot", {28'h0, i_hprot}, {28'h0, 2'b00, i_exp_priv, 1'b0});
			end
			if (core_i_dph_ready_o) begin
				check("core_i_dph_err_o", {31'h0, core_i_dph_err_o}, {31'h0, i_exp_err});
				if (!i_exp_err)
					check("core_i_rdata_o", core_i_rdata_o, ref_read(i_exp_addr));
			end

			// D-port address phase fields
			if (d_htrans == `CPU_BUS_HTRANS_NSEQ && d_hready) begin
				d_wait_idx <= d_wait_idx + 6'd1;
				if (d_hmaster == `CPU_BUS_HMASTER_CORE) begin
					core_aph_cyc <= cyc;
					check("d_haddr", d_haddr, core_exp_addr);
					check("d_hsize", {29'h0, d_hsize}, {29'h0, core_d_size_i});
					check("d_hwrite", {31'h0, d_hwrite}, {31'h0, core_exp_write});
					check("d_hprot", {28'h0, d_hprot}, {28'h0, 2'b00, core_exp_priv, 1'b1});
				end else begin
					sbus_aph_cyc <= cyc;
					check("d_hmaster", {24'h0, d_hmaster}, {24'h0, `CPU_BUS_HMASTER_SBUS});
					check("d_haddr", d_haddr, sbus_exp_addr);
					check("d_hsize", {29'h0, d_hsize}, {30'h0, sbus_size_i});
					check("d_hwrite", {31'h0, d_hwrite}, {31'h0, sbus_exp_write});
					check("d_hprot", {28'h0, d_hprot}, 32'h3);
				end
			end
			if (prev_stall) begin
				check("d_haddr", d_haddr, prev_haddr);
				check("d_hmaster", {24'h0, d_hmaster}, {24'h0, prev_hmaster});
			end
			prev_stall   <= (d_htrans == `CPU_BUS_HTRANS_NSEQ) && !d_hready && !d_hresp;
			prev_haddr   <= d_haddr;
			prev_hmaster <= d_hmaster;

			// Error only for the owner of the data phase
			if (core_d_dph_err_o || core_d_dph_ready_o)
				check("core_d_dph_err_o", {31'h0, core_d_dph_err_o}, {31'h0, core_exp_err});
			if (core_d_dph_ready_o && !core_exp_err) begin
				if (core_exp_write)
					shadow[core_exp_addr] = core_exp_wdata;
				else
					check("core_d_rdata_o", core_d_rdata_o, ref_read(core_exp_addr));
			end
			// No error expected once the owner's data phase is over
			if (core_d_dph_ready_o)
				core_exp_err = 1'b0;
			if (sbus_err_o || sbus_rdy_o)
				check("sbus_err_o", {31'h0, sbus_err_o}, {31'h0, sbus_exp_err});
			if (sbus_rdy_o && !sbus_exp_err) begin
				if (sbus_exp_write)
					shadow[sbus_exp_addr] = sbus_exp_wdata;
				else
					check("sbus_rdata_o", sbus_rdata_o, ref_read(sbus_exp_addr));
			end
			if (sbus_rdy_o)
				sbus_exp_err = 1'b0;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYC_LIMIT) begin
			$display("Timeout, run stopped after %0d cycles", cyc);
			$display("Test FAILED");
			$finish;
		end
	end

	// --------------------------------------------------
	// Test sequence

	initial begin
		logic [31:0] r;
		logic [31:0] st_addr [6];
		logic [31:0] dbg_addr [2];
		int          e0;

		clk = 1'b0;
		rst_n = 1'b0;
		errors = 0;
		n_checks = 0;
		cyc = 0;
		core_aph_cyc = 0;
		sbus_aph_cyc = 0;
		lfsr = 32'h95ae3d82;
		core_i_req_i = 1'b0;
		core_i_addr_i = 32'h0;
		core_i_size_i = 3'd2;
		core_i_priv_i = 1'b0;
		core_d_req_i = 1'b0;
		core_d_addr_i = 32'h0;
		core_d_size_i = 3'd2;
		core_d_priv_i = 1'b0;
		core_d_write_i = 1'b0;
		core_d_wdata_i = 32'h0;
		sbus_vld_i = 1'b0;
		sbus_addr_i = 32'h0;
		sbus_write_i = 1'b0;
		sbus_size_i = 2'd2;
		sbus_wdata_i = 32'h0;
		{i_exp_addr, core_exp_addr, core_exp_wdata, sbus_exp_addr, sbus_exp_wdata} = '0;
		{i_exp_priv, i_exp_err, core_exp_priv, core_exp_write, core_exp_err} = '0;
		{sbus_exp_write, sbus_exp_err} = '0;
		for (int k = 0; k < 64; k++) begin
			r = rand_bits(2);
			i_wait_tab[k] = r[1:0];
			r = rand_bits(2);
			d_wait_tab[k] = r[1:0];
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			r = rand_bits(9);
			fetch(32'h0000_1000 | {r[7:0], 2'b00}, r[8]);
		end
		report_test("fetch", e0);

		e0 = errors;
		for (int k = 0; k < 6; k++) begin
			r = rand_bits(6);
			st_addr[k] = 32'h0000_2000 | {r[5:0], 2'b00};
			core_xfer(st_addr[k], 1'b1, rand_bits(32), 1'b1);
		end
		for (int k = 0; k < 6; k++) begin
			r = rand_bits(1);
			core_xfer(st_addr[k], 1'b0, 32'h0, r[0]);
		end
		report_test("core load/store", e0);

		e0 = errors;
		for (int k = 0; k < 2; k++) begin
			r = rand_bits(6);
			dbg_addr[k] = 32'h0000_3000 | {r[5:0], 2'b00};
			sbus_xfer(dbg_addr[k], 1'b1, rand_bits(32));
		end
		sbus_xfer(dbg_addr[1], 1'b0, 32'h0);
		sbus_xfer(dbg_addr[0], 1'b0, 32'h0);
		report_test("debug access", e0);

		e0 = errors;
		for (int k = 0; k < 4; k++) begin
			fork
				core_xfer(32'h0000_2400 | {k[5:0], 2'b00}, 1'b1, rand_bits(32), 1'b0);
				sbus_xfer(32'h0000_3400 | {k[5:0], 2'b00}, 1'b0, 32'h0);
			join
			if (core_aph_cyc >= sbus_aph_cyc) begin
				$display("ERROR core address phase did not complete before the debugger's");
				errors++;
			end
		end
		report_test("contention", e0);

		e0 = errors;
		fork
			for (int k = 0; k < 4; k++)
				core_xfer(st_addr[k], 1'b0, 32'h0, 1'b0);
			for (int k = 0; k < 4; k++)
				sbus_xfer(32'h0000_3800 | {k[5:0], 2'b00}, 1'b0, 32'h0);
		join
		report_test("wait states", e0);

		e0 = errors;
		fetch(32'h8000_1000, 1'b1);
		core_xfer(32'h8000_2000, 1'b0, 32'h0, 1'b0);
		sbus_xfer(32'h8000_3000, 1'b0, 32'h0);
		report_test("error response", e0);

		errors += uut.u_dport_arbiter.u_cpu_bus_assertions.fail_cnt;
		$display("Checks %0d, errors %0d", n_checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/cpu_bus_2port.sv
// Two-port AHB-Lite bus front end for a small RISC-V core
// I port for fetch, D port shared by core load/store and debugger

`default_nettype none

`include "cpu_bus_defines.svh"

module cpu_bus_2port (
	input  wire                       clk,
	input  wire                       rst_n,

	// Core instruction side
	input  wire                       core_i_req_i,
	input  wire cpu_bus_pkg::addr_t   core_i_addr_i,
	input  wire cpu_bus_pkg::hsize_t  core_i_size_i,
	input  wire                       core_i_priv_i,
	output wire                       core_i_aph_ready_o,
	output wire                       core_i_dph_ready_o,
	output wire                       core_i_dph_err_o,
	output cpu_bus_pkg::data_t        core_i_rdata_o,

	// Core load/store side
	input  wire                       core_d_req_i,
	input  wire cpu_bus_pkg::addr_t   core_d_addr_i,
	input  wire cpu_bus_pkg::hsize_t  core_d_size_i,
	input  wire                       core_d_priv_i,
	input  wire                       core_d_write_i,
	input  wire cpu_bus_pkg::data_t   core_d_wdata_i,
	output wire                       core_d_aph_ready_o,
	output wire                       core_d_dph_ready_o,
	output wire                       core_d_dph_err_o,
	output cpu_bus_pkg::data_t        core_d_rdata_o,

	// Debugger system bus access
	input  wire                       sbus_vld_i,
	input  wire cpu_bus_pkg::addr_t   sbus_addr_i,
	input  wire                       sbus_write_i,
	input  wire [1:0]                 sbus_size_i,
	input  wire cpu_bus_pkg::data_t   sbus_wdata_i,
	output wire                       sbus_rdy_o,
	output wire                       sbus_err_o,
	output cpu_bus_pkg::data_t        sbus_rdata_o,

	// AHB-Lite I port
	output cpu_bus_pkg::addr_t        i_haddr_o,
	output cpu_bus_pkg::htrans_t      i_htrans_o,
	output cpu_bus_pkg::hsize_t       i_hsize_o,
	output cpu_bus_pkg::hprot_t       i_hprot_o,
	output wire                       i_hwrite_o,
	input  wire                       i_hready_i,
	input  wire                       i_hresp_i,
	input  wire cpu_bus_pkg::data_t   i_hrdata_i,

	// AHB-Lite D port
	output cpu_bus_pkg::addr_t        d_haddr_o,
	output cpu_bus_pkg::htrans_t      d_htrans_o,
	output cpu_bus_pkg::hsize_t       d_hsize_o,
	output cpu_bus_pkg::hprot_t       d_hprot_o,
	output wire                       d_hwrite_o,
	output wire [7:0]                 d_hmaster_o,
	output cpu_bus_pkg::data_t        d_hwdata_o,
	input  wire                       d_hready_i,
	input  wire                       d_hresp_i,
	input  wire cpu_bus_pkg::data_t   d_hrdata_i
);

	cpu_bus_pkg::dgrant_e d_gnt;
	logic                 sbus_dph_active;

	// --------------------------------------------------
	// Instruction port

	// Fetch port never writes
	assign i_hwrite_o = 1'b0;

	ifetch_port u_ifetch_port (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (core_i_req_i),
		.addr_i      (core_i_addr_i),
		.size_i      (core_i_size_i),
		.priv_i      (core_i_priv_i),
		.hready_i    (i_hready_i),
		.hresp_i     (i_hresp_i),
		.hrdata_i    (i_hrdata_i),
		.aph_ready_o (core_i_aph_ready_o),
		.dph_ready_o (core_i_dph_ready_o),
		.dph_err_o   (core_i_dph_err_o),
		.rdata_o     (core_i_rdata_o),
		.haddr_o     (i_haddr_o),
		.htrans_o    (i_htrans_o),
		.hsize_o     (i_hsize_o),
		.hprot_o     (i_hprot_o)
	);

	// --------------------------------------------------
	// Load/store port

	dport_arbiter u_dport_arbiter (
		.clk               (clk),
		.rst_n             (rst_n),
		.core_d_req_i      (core_d_req_i),
		.sbus_vld_i        (sbus_vld_i),
		.sbus_dph_active_i (sbus_dph_active),
		.d_htrans_i        (d_htrans_o),
		.d_hready_i        (d_hready_i),
		.d_hresp_i         (d_hresp_i),
		.gnt_o             (d_gnt)
	);

	dport_addr_mux u_dport_addr_mux (
		.gnt_i             (d_gnt),
		.core_addr_i       (core_d_addr_i),
		.core_size_i       (core_d_size_i),
		.core_priv_i       (core_d_priv_i),
		.core_write_i      (core_d_write_i),
		.core_wdata_i      (core_d_wdata_i),
		.sbus_addr_i       (sbus_addr_i),
		.sbus_write_i      (sbus_write_i),
		.sbus_size_i       (sbus_size_i),
		.sbus_wdata_i      (sbus_wdata_i),
		.sbus_dph_active_i (sbus_dph_active),
		.haddr_o           (d_haddr_o),
		.htrans_o          (d_htrans_o),
		.hsize_o           (d_hsize_o),
		.hwrite_o          (d_hwrite_o),
		.hprot_o           (d_hprot_o),
		.hmaster_o         (d_hmaster_o),
		.hwdata_o          (d_hwdata_o)
	);

	dport_resp_route u_dport_resp_route (
		.clk               (clk),
		.rst_n             (rst_n),
		.gnt_i             (d_gnt),
		.hready_i          (d_hready_i),
		.hresp_i           (d_hresp_i),
		.hrdata_i          (d_hrdata_i),
		.core_aph_ready_o  (core_d_aph_ready_o),
		.core_dph_ready_o  (core_d_dph_ready_o),
		.core_dph_err_o    (core_d_dph_err_o),
		.core_rdata_o      (core_d_rdata_o),
		.sbus_dph_active_o (sbus_dph_active),
		.sbus_rdy_o        (sbus_rdy_o),
		.sbus_err_o        (sbus_err_o),
		.sbus_rdata_o      (sbus_rdata_o)
	);

endmodule

`default_nettype wire

// File: hw/cpu_bus_defines.svh
// Bus widths, AHB transfer codes and D-port master IDs
// Shared by the package and every RTL block of the two-port front end

`ifndef CPU_BUS_DEFINES_SVH
`define CPU_BUS_DEFINES_SVH

// Address and data widths
`define CPU_BUS_W_ADDR 32
`define CPU_BUS_W_DATA 32

// HTRANS codes, only IDLE and NONSEQ are ever issued
`define CPU_BUS_HTRANS_IDLE 2'd0
`define CPU_BUS_HTRANS_NSEQ 2'd2

// HMASTER IDs on the D port
`define CPU_BUS_HMASTER_CORE 8'h00
`define CPU_BUS_HMASTER_SBUS 8'h01

`endif

// File: hw/cpu_bus_pkg.sv
// Bus vector types for the two-port front end
// Grant-state enum naming the owner of a D-port address phase

`default_nettype none

`include "cpu_bus_defines.svh"

package cpu_bus_pkg;

	// --------------------------------------------------
	// AHB field types

	typedef logic [`CPU_BUS_W_ADDR-1:0] addr_t;
	typedef logic [`CPU_BUS_W_DATA-1:0] data_t;
	typedef logic [2:0]                 hsize_t;
	typedef logic [3:0]                 hprot_t;
	typedef logic [1:0]                 htrans_t;

	// --------------------------------------------------
	// D-port address phase owner

	typedef enum logic [1:0] {
		DGNT_NONE = 2'd0,
		DGNT_CORE = 2'd1,
		DGNT_SBUS = 2'd2
	} dgrant_e;

endpackage

`default_nettype wire

// File: hw/dport_addr_mux.sv
// D-port address phase mux between core and debugger
// Also drives protection bits, master ID and data-phase write data

`default_nettype none

`include "cpu_bus_defines.svh"

module dport_addr_mux (
	input  wire cpu_bus_pkg::dgrant_e gnt_i,

	// Core load/store fields
	input  wire cpu_bus_pkg::addr_t   core_addr_i,
	input  wire cpu_bus_pkg::hsize_t  core_size_i,
	input  wire                       core_priv_i,
	input  wire                       core_write_i,
	input  wire cpu_bus_pkg::data_t   core_wdata_i,

	// Debugger fields
	input  wire cpu_bus_pkg::addr_t   sbus_addr_i,
	input  wire                       sbus_write_i,
	input  wire [1:0]                 sbus_size_i,
	input  wire cpu_bus_pkg::data_t   sbus_wdata_i,
	input  wire                       sbus_dph_active_i,

	// AHB D port
	output cpu_bus_pkg::addr_t        haddr_o,
	output cpu_bus_pkg::htrans_t      htrans_o,
	output cpu_bus_pkg::hsize_t       hsize_o,
	output logic                      hwrite_o,
	output cpu_bus_pkg::hprot_t       hprot_o,
	output logic [7:0]                hmaster_o,
	output cpu_bus_pkg::data_t        hwdata_o
);

	logic gnt_sbus;

	assign gnt_sbus = (gnt_i == cpu_bus_pkg::DGNT_SBUS);

	// --------------------------------------------------
	// Address phase fields

	assign htrans_o = (gnt_i != cpu_bus_pkg::DGNT_NONE) ?
		`CPU_BUS_HTRANS_NSEQ : `CPU_BUS_HTRANS_IDLE;

	assign haddr_o  = gnt_sbus ? sbus_addr_i          : core_addr_i;
	assign hwrite_o = gnt_sbus ? sbus_write_i         : core_write_i;
	assign hsize_o  = gnt_sbus ? {1'b0, sbus_size_i}  : core_size_i;

	// Data access, debugger always privileged
	assign hprot_o   = {2'b00, gnt_sbus || core_priv_i, 1'b1};
	assign hmaster_o = gnt_sbus ? `CPU_BUS_HMASTER_SBUS : `CPU_BUS_HMASTER_CORE;

	// Write data follows the data-phase owner, not the current grant
	assign hwdata_o = sbus_dph_active_i ? sbus_wdata_i : core_wdata_i;

endmodule

`default_nettype wire

// File: hw/dport_arbiter.sv
// D-port arbiter between core load/store and debugger system bus access
// Core has priority, a stalled address phase keeps its grant

`default_nettype none

`include "cpu_bus_defines.svh"

module dport_arbiter (
	input  wire                    clk,
	input  wire                    rst_n,

	// Requests
	input  wire                    core_d_req_i,
	input  wire                    sbus_vld_i,
	input  wire                    sbus_dph_active_i,

	// D-port bus state
	input  wire cpu_bus_pkg::htrans_t d_htrans_i,
	input  wire                    d_hready_i,
	input  wire                    d_hresp_i,

	output cpu_bus_pkg::dgrant_e   gnt_o
);

	// --------------------------------------------------
	// Hold state

	logic                 hold_aph;
	cpu_bus_pkg::dgrant_e gnt_prev;

	// Address phase presented but stretched by wait states.
	// An error response kills the transfer, so no hold then
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_aph <= 1'b0;
			gnt_prev <= cpu_bus_pkg::DGNT_NONE;
		end else begin
			hold_aph <= (d_htrans_i == `CPU_BUS_HTRANS_NSEQ) && !d_hready_i && !d_hresp_i;
			gnt_prev <= gnt_o;
		end
	end

	// --------------------------------------------------
	// Grant selection

	always_comb begin
		if (hold_aph) begin
			gnt_o = gnt_prev;
		end else if (core_d_req_i) begin
			gnt_o = cpu_bus_pkg::DGNT_CORE;
		end else if (sbus_vld_i && !sbus_dph_active_i) begin
			// Debugger only gets in with no debug data phase open
			gnt_o = cpu_bus_pkg::DGNT_SBUS;
		end else begin
			gnt_o = cpu_bus_pkg::DGNT_NONE;
		end
	end

endmodule

`default_nettype wire

// File: hw/dport_resp_route.sv
// D-port data phase ownership and response routing
// Sends ready, error and read data back to the core or the debugger

`default_nettype none

`include "cpu_bus_defines.svh"

module dport_resp_route (
	input  wire                       clk,
	input  wire                       rst_n,

	input  wire cpu_bus_pkg::dgrant_e gnt_i,
	input  wire                       hready_i,
	input  wire                       hresp_i,
	input  wire cpu_bus_pkg::data_t   hrdata_i,

	// Core response
	output logic                      core_aph_ready_o,
	output logic                      core_dph_ready_o,
	output logic                      core_dph_err_o,
	output cpu_bus_pkg::data_t        core_rdata_o,

	// Debugger response
	output logic                      sbus_dph_active_o,
	output logic                      sbus_rdy_o,
	output logic                      sbus_err_o,
	output cpu_bus_pkg::data_t        sbus_rdata_o
);

	logic core_dph_active;

	// --------------------------------------------------
	// Data phase owners, frozen while hready is low

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			core_dph_active   <= 1'b0;
			sbus_dph_active_o <= 1'b0;
		end else if (hready_i) begin
			core_dph_active   <= (gnt_i == cpu_bus_pkg::DGNT_CORE);
			sbus_dph_active_o <= (gnt_i == cpu_bus_pkg::DGNT_SBUS);
		end
	end

	// --------------------------------------------------
	// Responses

	assign core_aph_ready_o = hready_i && (gnt_i == cpu_bus_pkg::DGNT_CORE);
	assign core_dph_ready_o = core_dph_active && hready_i;
	// Error raised on the first cycle of the two-cycle response
	assign core_dph_err_o   = core_dph_active && hresp_i;
	assign core_rdata_o     = hrdata_i;

	assign sbus_rdy_o   = sbus_dph_active_o && hready_i;
	assign sbus_err_o   = sbus_dph_active_o && hresp_i;
	assign sbus_rdata_o = hrdata_i;

endmodule

`default_nettype wire

// File: hw/ifetch_port.sv
// Instruction fetch shim onto the AHB-Lite I port
// Tracks the data phase and returns fetch responses to the core

`default_nettype none

`include "cpu_bus_defines.svh"

module ifetch_port (
	input  wire                       clk,
	input  wire                       rst_n,

	// Core fetch request
	input  wire                       req_i,
	input  wire cpu_bus_pkg::addr_t   addr_i,
	input  wire cpu_bus_pkg::hsize_t  size_i,
	input  wire                       priv_i,

	// AHB response
	input  wire                       hready_i,
	input  wire                       hresp_i,
	input  wire cpu_bus_pkg::data_t   hrdata_i,

	// Core response
	output logic                      aph_ready_o,
	output logic                      dph_ready_o,
	output logic                      dph_err_o,
	output cpu_bus_pkg::data_t        rdata_o,

	// AHB address phase
	output cpu_bus_pkg::addr_t        haddr_o,
	output cpu_bus_pkg::htrans_t      htrans_o,
	output cpu_bus_pkg::hsize_t       hsize_o,
	output cpu_bus_pkg::hprot_t       hprot_o
);

	logic dph_active;

	// --------------------------------------------------
	// Address phase

	assign haddr_o  = addr_i;
	assign hsize_o  = size_i;
	assign htrans_o = req_i ? `CPU_BUS_HTRANS_NSEQ : `CPU_BUS_HTRANS_IDLE;

	// Non-cacheable, non-bufferable instruction fetch
	assign hprot_o = {2'b00, priv_i, 1'b0};

	// --------------------------------------------------
	// Data phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active <= 1'b0;
		end else if (hready_i) begin
			dph_active <= req_i;
		end
	end

	assign aph_ready_o = req_i && hready_i;
	assign dph_ready_o = dph_active && hready_i;
	// Fetch errors only seen on the final response cycle
	assign dph_err_o   = dph_active && hready_i && hresp_i;
	assign rdata_o     = hrdata_i;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_cpu_bus_2port -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verilog.f
+incdir+hw
hw/cpu_bus_pkg.sv
hw/dport_arbiter.sv
hw/ifetch_port.sv
hw/dport_addr_mux.sv
hw/dport_resp_route.sv
hw/cpu_bus_2port.sv
dv/cpu_bus_assertions.sv
dv/tb_cpu_bus_2port.sv
